/* Makefile */
# Verilator build and run of the ALU cluster testbench

VERILATOR ?= verilator
TOP       ?= alu_cluster_tb
FILELIST  ?= alu_cluster.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* alu_cluster.f */
hdl/rs_pkg.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/alu_cluster.sv
test/reservation_station_assert.sv
test/alu_cluster_tb.sv

/* hdl/alu_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic                 delete_tag,
  input  logic                 clear_tag,

  input  rs_pkg::instr_type_e  issue0_type,
  input  rs_pkg::instr_name_e  issue0_name,
  input  rs_pkg::data_t        issue0_data_1,
  input  rs_pkg::data_t        issue0_data_2,
  input  rs_pkg::reg_tag_t     issue0_src_1,
  input  rs_pkg::reg_tag_t     issue0_src_2,
  input  logic                 issue0_valid_1,
  input  logic                 issue0_valid_2,
  input  rs_pkg::reg_tag_t     issue0_rrn,
  input  logic                 issue0_tag,

  input  rs_pkg::instr_type_e  issue1_type,
  input  rs_pkg::instr_name_e  issue1_name,
  input  rs_pkg::data_t        issue1_data_1,
  input  rs_pkg::data_t        issue1_data_2,
  input  rs_pkg::reg_tag_t     issue1_src_1,
  input  rs_pkg::reg_tag_t     issue1_src_2,
  input  logic                 issue1_valid_1,
  input  logic                 issue1_valid_2,
  input  rs_pkg::reg_tag_t     issue1_rrn,
  input  logic                 issue1_tag,

  input  logic                 cdb1_valid, // load unit side
  input  rs_pkg::reg_tag_t     cdb1_rrn,
  input  rs_pkg::data_t        cdb1_result,

  output logic                 full,
  output logic                 cdb0_valid,
  output rs_pkg::reg_tag_t     cdb0_rrn,
  output rs_pkg::data_t        cdb0_result
);

  // --------------------------------------------------------------------------
  // station to ALU
  // --------------------------------------------------------------------------
  rs_pkg::instr_name_e disp_name;
  rs_pkg::data_t       disp_data_1;
  rs_pkg::data_t       disp_data_2;
  rs_pkg::reg_tag_t    disp_rrn;
  logic                alu_ready;

  reservation_station rs (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .delete_tag     (delete_tag),
    .clear_tag      (clear_tag),
    .issue0_type    (issue0_type),
    .issue0_name    (issue0_name),
    .issue0_data_1  (issue0_data_1),
    .issue0_data_2  (issue0_data_2),
    .issue0_src_1   (issue0_src_1),
    .issue0_src_2   (issue0_src_2),
    .issue0_valid_1 (issue0_valid_1),
    .issue0_valid_2 (issue0_valid_2),
    .issue0_rrn     (issue0_rrn),
    .issue0_tag     (issue0_tag),
    .issue1_type    (issue1_type),
    .issue1_name    (issue1_name),
    .issue1_data_1  (issue1_data_1),
    .issue1_data_2  (issue1_data_2),
    .issue1_src_1   (issue1_src_1),
    .issue1_src_2   (issue1_src_2),
    .issue1_valid_1 (issue1_valid_1),
    .issue1_valid_2 (issue1_valid_2),
    .issue1_rrn     (issue1_rrn),
    .issue1_tag     (issue1_tag),
    .cdb0_valid     (cdb0_valid),   // own result loops back
    .cdb0_rrn       (cdb0_rrn),
    .cdb0_result    (cdb0_result),
    .cdb1_valid     (cdb1_valid),
    .cdb1_rrn       (cdb1_rrn),
    .cdb1_result    (cdb1_result),
    .next           (alu_ready),
    .instr_name     (disp_name),
    .data_1         (disp_data_1),
    .data_2         (disp_data_2),
    .rrn            (disp_rrn),
    .full           (full)
  );

  alu_unit alu (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .instr_name   (disp_name),
    .data_1       (disp_data_1),
    .data_2       (disp_data_2),
    .rrn          (disp_rrn),
    .ready        (alu_ready),
    .result_valid (cdb0_valid),
    .result_rrn   (cdb0_rrn),
    .result       (cdb0_result)
  );

endmodule

`default_nettype wire

/* hdl/alu_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  rs_pkg::instr_name_e  instr_name,
  input  rs_pkg::data_t        data_1,
  input  rs_pkg::data_t        data_2,
  input  rs_pkg::reg_tag_t     rrn,
  output logic                 ready,
  output logic                 result_valid,
  output rs_pkg::reg_tag_t     result_rrn,
  output rs_pkg::data_t        result
);

  typedef enum logic {alu_idle, alu_mul_busy} alu_state_e;

  function automatic rs_pkg::data_t compute(input rs_pkg::instr_name_e op,
                                            input rs_pkg::data_t a, input rs_pkg::data_t b);
    case (op)
      rs_pkg::op_add: return a + b;
      rs_pkg::op_sub: return a - b;
      rs_pkg::op_and: return a & b;
      rs_pkg::op_or:  return a | b;
      rs_pkg::op_xor: return a ^ b;
      rs_pkg::op_sll: return a << b[4:0];
      rs_pkg::op_srl: return a >> b[4:0];
      rs_pkg::op_slt: return {31'b0, $signed(a) < $signed(b)};
      rs_pkg::op_mul: return a * b; // low word only
      default:        return '0;
    endcase
  endfunction

  alu_state_e state;
  logic [$clog2(rs_pkg::MUL_LATENCY)-1:0] mul_cnt;
  rs_pkg::data_t    mul_res;
  rs_pkg::reg_tag_t mul_rrn;
  logic             mul_done;

  assign mul_done = (state == alu_mul_busy) && (mul_cnt == 1'b1);

  // low in the cycle a multiply arrives and while it runs
  assign ready = (state == alu_idle) && (instr_name != rs_pkg::op_mul);

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      state        <= alu_idle;
      mul_cnt      <= '0;
      result_valid <= 1'b0;
    end else begin
      case (state)
        alu_idle: begin
          result_valid <= (instr_name != rs_pkg::op_none) && (instr_name != rs_pkg::op_mul);
          if (instr_name == rs_pkg::op_mul) begin
            state   <= alu_mul_busy;
            mul_cnt <= $bits(mul_cnt)'(rs_pkg::MUL_LATENCY - 1);
          end
        end
        alu_mul_busy: begin
          mul_cnt      <= mul_cnt - 1'b1;
          result_valid <= mul_done;
          if (mul_done) state <= alu_idle;
        end
        default: state <= alu_idle;
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    if (state == alu_idle && instr_name == rs_pkg::op_mul) begin
      mul_res <= compute(instr_name, data_1, data_2);
      mul_rrn <= rrn;
    end else if (state == alu_idle && instr_name != rs_pkg::op_none) begin
      result     <= compute(instr_name, data_1, data_2);
      result_rrn <= rrn;
    end
    if (mul_done) begin
      result     <= mul_res;
      result_rrn <= mul_rrn;
    end
  end

endmodule

`default_nettype wire

/* hdl/reservation_station.sv */
`timescale 1ns/10ps
`default_nettype none

module reservation_station (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic                 delete_tag,
  input  logic                 clear_tag,

  input  rs_pkg::instr_type_e  issue0_type,
  input  rs_pkg::instr_name_e  issue0_name,
  input  rs_pkg::data_t        issue0_data_1,
  input  rs_pkg::data_t        issue0_data_2,
  input  rs_pkg::reg_tag_t     issue0_src_1,
  input  rs_pkg::reg_tag_t     issue0_src_2,
  input  logic                 issue0_valid_1,
  input  logic                 issue0_valid_2,
  input  rs_pkg::reg_tag_t     issue0_rrn,
  input  logic                 issue0_tag,

  input  rs_pkg::instr_type_e  issue1_type,
  input  rs_pkg::instr_name_e  issue1_name,
  input  rs_pkg::data_t        issue1_data_1,
  input  rs_pkg::data_t        issue1_data_2,
  input  rs_pkg::reg_tag_t     issue1_src_1,
  input  rs_pkg::reg_tag_t     issue1_src_2,
  input  logic                 issue1_valid_1,
  input  logic                 issue1_valid_2,
  input  rs_pkg::reg_tag_t     issue1_rrn,
  input  logic                 issue1_tag,

  input  logic                 cdb0_valid,
  input  rs_pkg::reg_tag_t     cdb0_rrn,
  input  rs_pkg::data_t        cdb0_result,
  input  logic                 cdb1_valid,
  input  rs_pkg::reg_tag_t     cdb1_rrn,
  input  rs_pkg::data_t        cdb1_result,

  input  logic                 next,
  output rs_pkg::instr_name_e  instr_name,
  output rs_pkg::data_t        data_1,
  output rs_pkg::data_t        data_2,
  output rs_pkg::reg_tag_t     rrn,
  output logic                 full
);

  // --------------------------------------------------------------------------
  // bus snooping
  // --------------------------------------------------------------------------
  function automatic logic bus_hit(input rs_pkg::reg_tag_t src, input logic vld,
                                   input logic bus_vld, input rs_pkg::reg_tag_t bus_rrn);
    return bus_vld && !vld && (src == bus_rrn);
  endfunction

  function automatic rs_pkg::data_t snoop_data(input rs_pkg::data_t cur,
                                               input rs_pkg::reg_tag_t src, input logic vld);
    if (bus_hit(src, vld, cdb0_valid, cdb0_rrn)) return cdb0_result;
    if (bus_hit(src, vld, cdb1_valid, cdb1_rrn)) return cdb1_result;
    return cur;
  endfunction

  function automatic logic snoop_valid(input rs_pkg::reg_tag_t src, input logic vld);
    return vld || bus_hit(src, vld, cdb0_valid, cdb0_rrn) ||
           bus_hit(src, vld, cdb1_valid, cdb1_rrn);
  endfunction

  // --------------------------------------------------------------------------
  // entry storage
  // --------------------------------------------------------------------------
  rs_pkg::instr_name_e name_q   [rs_pkg::RS_SIZE];
  rs_pkg::data_t       data_1_q [rs_pkg::RS_SIZE];
  rs_pkg::data_t       data_2_q [rs_pkg::RS_SIZE];
  rs_pkg::reg_tag_t    src_1_q  [rs_pkg::RS_SIZE];
  rs_pkg::reg_tag_t    src_2_q  [rs_pkg::RS_SIZE];
  rs_pkg::reg_tag_t    rrn_q    [rs_pkg::RS_SIZE];

  logic [rs_pkg::RS_SIZE-1:0] valid_1_q;
  logic [rs_pkg::RS_SIZE-1:0] valid_2_q;
  logic [rs_pkg::RS_SIZE-1:0] tag_q;  // issued past an open branch
  logic [rs_pkg::RS_SIZE-1:0] skip_q; // squashed, drop at head

  rs_pkg::rs_index_t rd_idx;
  rs_pkg::rs_index_t wr_idx;
  rs_pkg::rs_index_t wr_idx_1;
  rs_pkg::rs_count_t count;

  logic       take_0;
  logic       take_1;
  logic [1:0] n_take;
  logic       head_go;  // head leaves the queue
  logic       dispatch; // head goes to the ALU

  assign full = (count >= rs_pkg::rs_count_t'(rs_pkg::RS_SIZE - 1));

  assign take_0 = (issue0_type == rs_pkg::type_alu) && !full && !delete_tag;
  assign take_1 = (issue1_type == rs_pkg::type_alu) && !full && !delete_tag;
  assign n_take = {1'b0, take_0} + {1'b0, take_1};

  // slot 1 lands behind slot 0 only if slot 0 was taken
  assign wr_idx_1 = wr_idx + rs_pkg::rs_index_t'(take_0);

  assign head_go = (count != '0) && !delete_tag &&
                   (skip_q[rd_idx] || (valid_1_q[rd_idx] && valid_2_q[rd_idx] && next));
  assign dispatch = head_go && !skip_q[rd_idx];

  // --------------------------------------------------------------------------
  // payload, snoop and issue write
  // --------------------------------------------------------------------------
  always_ff @(posedge global_bus) begin
    for (int j = 0; j < rs_pkg::RS_SIZE; j++) begin
      data_1_q[j] <= snoop_data(data_1_q[j], src_1_q[j], valid_1_q[j]);
      data_2_q[j] <= snoop_data(data_2_q[j], src_2_q[j], valid_2_q[j]);
    end
    if (take_0) begin
      name_q[wr_idx]   <= issue0_name;
      src_1_q[wr_idx]  <= issue0_src_1;
      src_2_q[wr_idx]  <= issue0_src_2;
      rrn_q[wr_idx]    <= issue0_rrn;
      data_1_q[wr_idx] <= snoop_data(issue0_data_1, issue0_src_1, issue0_valid_1);
      data_2_q[wr_idx] <= snoop_data(issue0_data_2, issue0_src_2, issue0_valid_2);
    end
    if (take_1) begin
      name_q[wr_idx_1]   <= issue1_name;
      src_1_q[wr_idx_1]  <= issue1_src_1;
      src_2_q[wr_idx_1]  <= issue1_src_2;
      rrn_q[wr_idx_1]    <= issue1_rrn;
      data_1_q[wr_idx_1] <= snoop_data(issue1_data_1, issue1_src_1, issue1_valid_1);
      data_2_q[wr_idx_1] <= snoop_data(issue1_data_2, issue1_src_2, issue1_valid_2);
    end
    if (dispatch) begin
      data_1 <= data_1_q[rd_idx];
      data_2 <= data_2_q[rd_idx];
      rrn    <= rrn_q[rd_idx];
    end
  end

  // --------------------------------------------------------------------------
  // flags and pointers
  // --------------------------------------------------------------------------
  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      valid_1_q <= '0;
      valid_2_q <= '0;
      tag_q     <= '0;
      skip_q    <= '0;
      rd_idx    <= '0;
      wr_idx    <= '0;
      count     <= '0;
    end else begin
      for (int j = 0; j < rs_pkg::RS_SIZE; j++) begin
        valid_1_q[j] <= snoop_valid(src_1_q[j], valid_1_q[j]);
        valid_2_q[j] <= snoop_valid(src_2_q[j], valid_2_q[j]);
      end
      if (clear_tag) tag_q <= '0;              // branch resolved taken-as-predicted
      if (delete_tag) skip_q <= skip_q | tag_q; // mispredict
      if (take_0) begin
        valid_1_q[wr_idx] <= snoop_valid(issue0_src_1, issue0_valid_1);
        valid_2_q[wr_idx] <= snoop_valid(issue0_src_2, issue0_valid_2);
        tag_q[wr_idx]     <= issue0_tag;
        skip_q[wr_idx]    <= 1'b0;
      end
      if (take_1) begin
        valid_1_q[wr_idx_1] <= snoop_valid(issue1_src_1, issue1_valid_1);
        valid_2_q[wr_idx_1] <= snoop_valid(issue1_src_2, issue1_valid_2);
        tag_q[wr_idx_1]     <= issue1_tag;
        skip_q[wr_idx_1]    <= 1'b0;
      end
      if (head_go) rd_idx <= rd_idx + 1'b1;
      wr_idx <= wr_idx + rs_pkg::rs_index_t'(n_take);
      count  <= count + rs_pkg::rs_count_t'(n_take) - rs_pkg::rs_count_t'(head_go);
    end
  end

  // dispatch pulse, one cycle per instruction
  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      instr_name <= rs_pkg::op_none;
    end else begin
      instr_name <= dispatch ? name_q[rd_idx] : rs_pkg::op_none;
    end
  end

endmodule

`default_nettype wire

/* hdl/rs_pkg.sv */
`default_nettype none

package rs_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] data_t;    // operand or result value
  typedef logic [5:0]  reg_tag_t; // rename tag of the producer

  // --------------------------------------------------------------------------
  // station sizing
  // --------------------------------------------------------------------------
  localparam int RS_SIZE    = 8; // power of two, indexes wrap
  localparam int RS_INDEX_W = $clog2(RS_SIZE);

  typedef logic [RS_INDEX_W-1:0] rs_index_t;
  typedef logic [RS_INDEX_W:0]   rs_count_t; // one wider, holds a full queue

  // cycles from dispatch pulse to result for a multiply
  localparam int MUL_LATENCY = 3;

  // --------------------------------------------------------------------------
  // encodings
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    op_none,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_mul
  } instr_name_e;

  typedef enum logic [1:0] {
    type_none, // empty issue slot
    type_alu,
    type_mem,
    type_branch
  } instr_type_e;

endpackage

`default_nettype wire

/* test/alu_cluster_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_INSTR  = 200;
  localparam int WATCHDOG   = NUM_INSTR * 40; // cycles
  localparam int DRAIN      = 40;              // covers a full broadcast backlog

  logic global_bus = 1'b0;
  logic rst_n;
  logic delete_tag;
  logic clear_tag;
  logic full;

  rs_pkg::instr_type_e issue0_type, issue1_type;
  rs_pkg::instr_name_e issue0_name, issue1_name;
  rs_pkg::data_t       issue0_data_1, issue0_data_2, issue1_data_1, issue1_data_2;
  rs_pkg::reg_tag_t    issue0_src_1, issue0_src_2, issue0_rrn;
  rs_pkg::reg_tag_t    issue1_src_1, issue1_src_2, issue1_rrn;
  logic                issue0_valid_1, issue0_valid_2, issue0_tag;
  logic                issue1_valid_1, issue1_valid_2, issue1_tag;

  logic             cdb0_valid;
  logic             cdb1_valid;
  rs_pkg::reg_tag_t cdb0_rrn;
  rs_pkg::reg_tag_t cdb1_rrn;
  rs_pkg::data_t    cdb0_result;
  rs_pkg::data_t    cdb1_result;

  integer           seed;
  int               cyc = 0;
  int               issued = 0;
  rs_pkg::reg_tag_t ext_tag = 6'd32; // load unit tags live in 32..63

  // expected results in program order
  rs_pkg::reg_tag_t exp_rrn [$];
  rs_pkg::data_t    exp_val [$];
  logic             exp_tag [$]; // still speculative
  logic             exp_opt [$]; // hit by a delete and may never show up

  // broadcasts owed on cdb1
  rs_pkg::reg_tag_t pend_tag [$];
  rs_pkg::data_t    pend_val [$];
  int               pend_due [$];

  alu_cluster UUT (.*);

  bind reservation_station reservation_station_assert rs_chk (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .delete_tag (delete_tag),
    .next       (next),
    .count      (count),
    .instr_name (instr_name)
  );

  always #(CLK_PERIOD / 2) global_bus = ~global_bus;

  // --------------------------------------------------------------------------
  // model and checks
  // --------------------------------------------------------------------------
  function automatic int rnd_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic rs_pkg::data_t model_result(input rs_pkg::instr_name_e op,
                                                 input rs_pkg::data_t a, input rs_pkg::data_t b);
    case (op)
      rs_pkg::op_add: return a + b;
      rs_pkg::op_sub: return a + ~b + 32'd1;
      rs_pkg::op_and: return a & b;
      rs_pkg::op_or:  return a | b;
      rs_pkg::op_xor: return a ^ b;
      rs_pkg::op_sll: return a << b[4:0];
      rs_pkg::op_srl: return a >> b[4:0];
      // differing signs decide alone and equal signs compare as unsigned
      rs_pkg::op_slt: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      rs_pkg::op_mul: return a * b;
      default:        return '0;
    endcase
  endfunction

  function automatic int required_left();
    int n = 0;
    foreach (exp_opt[i])
      if (!exp_opt[i]) n++;
    return n;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rrn(input string sig, input rs_pkg::reg_tag_t got,
                           input rs_pkg::reg_tag_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at time %0t: %s is %0d, expected %0d", $time, sig, got, exp));
  endtask

  task automatic check_result(input string sig, input rs_pkg::data_t got,
                              input rs_pkg::data_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h", $time, sig, got, exp));
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at time %0t: %s is %b, expected %b", $time, sig, got, exp));
  endtask

  task automatic drop_front();
    exp_rrn.delete(0);
    exp_val.delete(0);
    exp_tag.delete(0);
    exp_opt.delete(0);
  endtask

  task automatic watch_cdb0();
    if (cdb0_valid) begin
      // squashed instructions leave no result
      while (exp_rrn.size() > 0 && exp_opt[0] && exp_rrn[0] != cdb0_rrn)
        drop_front();
      if (exp_rrn.size() == 0) begin
        abort_run($sformatf("cdb0 result for rrn %0d with nothing outstanding", cdb0_rrn));
      end else begin
        check_rrn("cdb0_rrn", cdb0_rrn, exp_rrn[0]);
        check_result("cdb0_result", cdb0_result, exp_val[0]);
        drop_front();
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic make_source(output rs_pkg::data_t d, output rs_pkg::reg_tag_t src,
                             output logic vld, output rs_pkg::data_t value);
    value = $random(seed);
    if (rnd_below(3) == 0 && pend_tag.size() < 32) begin
      src = ext_tag;
      vld = 1'b0;
      d   = $random(seed); // stale value that the broadcast replaces
      pend_tag.push_back(ext_tag);
      pend_val.push_back(value);
      pend_due.push_back(cyc + rnd_below(5)); // zero means same cycle as issue
      ext_tag = (ext_tag == 6'd63) ? 6'd32 : ext_tag + 6'd1;
    end else begin
      src = rs_pkg::reg_tag_t'(rnd_below(64));
      vld = 1'b1;
      d   = value;
    end
  endtask

  task automatic fill_slot(input logic real_alu, input logic junk_alu,
                           output rs_pkg::instr_type_e typ, output rs_pkg::instr_name_e name,
                           output rs_pkg::data_t d1, output rs_pkg::data_t d2,
                           output rs_pkg::reg_tag_t src1, output rs_pkg::reg_tag_t src2,
                           output logic v1, output logic v2,
                           output rs_pkg::reg_tag_t rrn, output logic tag);
    rs_pkg::data_t a;
    rs_pkg::data_t b;
    name = rs_pkg::instr_name_e'(1 + rnd_below(9));
    tag  = (rnd_below(4) == 0);
    if (real_alu) begin
      typ = rs_pkg::type_alu;
      make_source(d1, src1, v1, a);
      make_source(d2, src2, v2, b);
      rrn = rs_pkg::reg_tag_t'(issued % 32);
      exp_rrn.push_back(rrn);
      exp_val.push_back(model_result(name, a, b));
      exp_tag.push_back(tag);
      exp_opt.push_back(1'b0);
      issued++;
    end else begin
      typ = rs_pkg::instr_type_e'(rnd_below(4));
      if (typ == rs_pkg::type_alu && !junk_alu) typ = rs_pkg::type_mem;
      d1   = $random(seed);
      d2   = $random(seed);
      src1 = rs_pkg::reg_tag_t'(rnd_below(64));
      src2 = rs_pkg::reg_tag_t'(rnd_below(64));
      v1   = (rnd_below(2) == 1);
      v2   = (rnd_below(2) == 1);
      rrn  = rs_pkg::reg_tag_t'(rnd_below(64));
    end
  endtask

  task automatic drive_cdb1();
    cdb1_valid = 1'b0;
    if (pend_tag.size() > 0 && pend_due[0] <= cyc) begin
      cdb1_valid  = 1'b1;
      cdb1_rrn    = pend_tag.pop_front();
      cdb1_result = pend_val.pop_front();
      pend_due.delete(0);
    end
  endtask

  task automatic run_cycle();
    logic open;
    @(negedge global_bus);
    watch_cdb0();
    cyc++;
    delete_tag = (rnd_below(30) == 0);
    clear_tag  = !delete_tag && (rnd_below(15) == 0);
    if (clear_tag)
      foreach (exp_tag[i]) exp_tag[i] = 1'b0;
    if (delete_tag)
      foreach (exp_tag[i])
        if (exp_tag[i]) exp_opt[i] = 1'b1;
    open = !full && !delete_tag;
    // an unmodelled ALU slot is only offered where the station must refuse it
    fill_slot(open && issued < NUM_INSTR && rnd_below(3) != 0, delete_tag && !full,
              issue0_type, issue0_name, issue0_data_1, issue0_data_2, issue0_src_1,
              issue0_src_2, issue0_valid_1, issue0_valid_2, issue0_rrn, issue0_tag);
    fill_slot(open && issued < NUM_INSTR && rnd_below(3) != 0, delete_tag && !full,
              issue1_type, issue1_name, issue1_data_1, issue1_data_2, issue1_src_1,
              issue1_src_2, issue1_valid_1, issue1_valid_2, issue1_rrn, issue1_tag);
    drive_cdb1();
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    seed        = 78;
    rst_n       = 1'b0;
    delete_tag  = 1'b0;
    clear_tag   = 1'b0;
    cdb1_valid  = 1'b0;
    cdb1_rrn    = '0;
    cdb1_result = '0;
    fill_slot(1'b0, 1'b0, issue0_type, issue0_name, issue0_data_1, issue0_data_2, issue0_src_1,
              issue0_src_2, issue0_valid_1, issue0_valid_2, issue0_rrn, issue0_tag);
    fill_slot(1'b0, 1'b0, issue1_type, issue1_name, issue1_data_1, issue1_data_2, issue1_src_1,
              issue1_src_2, issue1_valid_1, issue1_valid_2, issue1_rrn, issue1_tag);
    repeat (16) @(negedge global_bus);
    rst_n = 1'b1;
    @(negedge global_bus);
    check_flag("full", full, 1'b0);
    check_flag("cdb0_valid", cdb0_valid, 1'b0);
    while (issued < NUM_INSTR || required_left() > 0)
      run_cycle();
    repeat (DRAIN) run_cycle(); // squashed tails and leftover broadcasts
    check_flag("full", full, 1'b0);
    if (required_left() == 0 && pend_tag.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run("results or cdb1 broadcasts still outstanding after the drain");
    end
  end

  initial begin
    #(WATCHDOG * CLK_PERIOD);
    abort_run($sformatf("watchdog expired with %0d of %0d instructions issued", issued, NUM_INSTR));
  end

endmodule

`default_nettype wire

/* test/reservation_station_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module reservation_station_assert (
  input logic                global_bus,
  input logic                rst_n,
  input logic                delete_tag,
  input logic                next,
  input rs_pkg::rs_count_t   count,
  input rs_pkg::instr_name_e instr_name
);

  // --------------------------------------------------------------------------
  // queue occupancy
  // --------------------------------------------------------------------------
  count_bounded: assert property (@(posedge global_bus) disable iff (!rst_n)
    count <= rs_pkg::rs_count_t'(rs_pkg::RS_SIZE))
    else $error("station count %0d above RS_SIZE", count);

  // --------------------------------------------------------------------------
  // dispatch gating shows on the pulse one cycle after the decision
  // --------------------------------------------------------------------------
  no_dispatch_busy: assert property (@(posedge global_bus) disable iff (!rst_n)
    !next |=> instr_name == rs_pkg::op_none)
    else $error("dispatch while the ALU was not ready");

  no_dispatch_squash: assert property (@(posedge global_bus) disable iff (!rst_n)
    delete_tag |=> instr_name == rs_pkg::op_none)
    else $error("dispatch in a delete_tag cycle");

endmodule

`default_nettype wire
